// ==== smu_ctl_pkg.sv ====
// shared types and constants for the smu board-control block
// register addresses, array indices, reset defaults, frame sizes
`default_nettype none

package smu_ctl_pkg;

  ////////////////////////////////////////////////////////////
  // types

  // one control register, 4 bits wide
  typedef logic [3:0] ctl_nib_t;

  // slot of a kept register in the array
  typedef logic [2:0] ctl_idx_t;

  ////////////////////////////////////////////////////////////
  // sizes

  localparam int FRAME_BITS = 16;
  localparam int NUM_CTL    = 8;

  // adc03, dac, flash, adc02 from bit 0 up
  localparam int NUM_PERIPH = 4;

  // returned during the address byte
  localparam logic [7:0] IDENT_BYTE = 8'h5a;

  ////////////////////////////////////////////////////////////
  // spi register addresses

  localparam logic [7:0] ADDR_LED         = 8'd7;
  localparam logic [7:0] ADDR_MUX         = 8'd8;
  localparam logic [7:0] ADDR_DAC         = 8'd9;
  localparam logic [7:0] ADDR_RAILS       = 8'd10;
  localparam logic [7:0] ADDR_SOFT_RST    = 8'd11;
  localparam logic [7:0] ADDR_DAC_REF_MUX = 8'd12;
  localparam logic [7:0] ADDR_ADC         = 8'd14;
  localparam logic [7:0] ADDR_CLAMP1      = 8'd15;
  localparam logic [7:0] ADDR_RAILS_OE    = 8'd24;

  // array slots, same order as the defaults table
  localparam ctl_idx_t IDX_LED         = 3'd0;
  localparam ctl_idx_t IDX_MUX         = 3'd1;
  localparam ctl_idx_t IDX_DAC         = 3'd2;
  localparam ctl_idx_t IDX_RAILS       = 3'd3;
  localparam ctl_idx_t IDX_DAC_REF_MUX = 3'd4;
  localparam ctl_idx_t IDX_ADC         = 3'd5;
  localparam ctl_idx_t IDX_CLAMP1      = 3'd6;
  localparam ctl_idx_t IDX_RAILS_OE    = 3'd7;

  // nibble i of the table is the default of slot i
  // dac_ref_mux and clamp1 are active low, so they start off (1111)
  // rails_oe bit 0 keeps the rails disabled until the host enables them
  localparam logic [31:0] CTL_DEFAULTS = 32'h1f0f_0000;

endpackage

`default_nettype wire

// ==== spi_input_sync.sv ====
// two-flop synchronizers for the spi pins
// sclk and cs_n edge pulses, select level, data level
`timescale 1ns/100ps
`default_nettype none

module spi_input_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic special_n,
  input  logic mosi,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic frame_start,
  output logic frame_end,
  output logic sel_active,
  output logic mosi_s
);

  // sync stages, first and second
  logic sclk_q1, sclk_q2;
  logic cs_n_q1, cs_n_q2;
  logic spec_q1, spec_q2;
  logic mosi_q1, mosi_q2;

  // previous samples for edge detection
  logic sclk_prev;
  logic cs_n_prev;

  // idle levels on reset: sclk low, selects high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_q1   <= 1'b0;
      sclk_q2   <= 1'b0;
      cs_n_q1   <= 1'b1;
      cs_n_q2   <= 1'b1;
      spec_q1   <= 1'b1;
      spec_q2   <= 1'b1;
      mosi_q1   <= 1'b0;
      mosi_q2   <= 1'b0;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
    end
    else
    begin
      sclk_q1   <= sclk;
      sclk_q2   <= sclk_q1;
      cs_n_q1   <= cs_n;
      cs_n_q2   <= cs_n_q1;
      spec_q1   <= special_n;
      spec_q2   <= spec_q1;
      mosi_q1   <= mosi;
      mosi_q2   <= mosi_q1;
      sclk_prev <= sclk_q2;
      cs_n_prev <= cs_n_q2;
    end
  end

  // one-cycle pulses
  assign sclk_rise   = sclk_q2 & ~sclk_prev;
  assign sclk_fall   = ~sclk_q2 & sclk_prev;
  assign frame_start = ~cs_n_q2 & cs_n_prev;
  assign frame_end   = cs_n_q2 & ~cs_n_prev;

  // levels
  assign sel_active = ~spec_q2;
  assign mosi_s     = mosi_q2;

endmodule

`default_nettype wire

// ==== spi_frame_shifter.sv ====
// spi frame receiver, msb first, sampled on sclk rise
// write strobe on frame close, readback shifter on sclk fall
`timescale 1ns/100ps
`default_nettype none

module spi_frame_shifter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sclk_rise,
  input  logic                  sclk_fall,
  input  logic                  frame_start,
  input  logic                  frame_end,
  input  logic                  sel_active,
  input  logic                  mosi_s,
  input  smu_ctl_pkg::ctl_nib_t rd_data,
  output logic                  wr_strobe,
  output logic [7:0]            wr_addr,
  output logic [7:0]            wr_val,
  output logic [7:0]            rd_addr,
  output logic                  dout
);

  import smu_ctl_pkg::*;

  // count saturates one past a full frame, so long frames are rejected
  localparam logic [4:0] CNT_FULL = 5'(FRAME_BITS);
  localparam logic [4:0] CNT_SAT  = 5'(FRAME_BITS + 1);
  // last bit of the address byte, and the point where readback is loaded
  localparam logic [4:0] CNT_ADDR = 5'(FRAME_BITS / 2 - 1);
  localparam logic [4:0] CNT_LOAD = 5'(FRAME_BITS / 2);

  logic        frame_open;
  logic        sel_ok;
  logic [4:0]  bit_cnt;
  logic [15:0] shift_in;
  logic [7:0]  tx_sh;
  logic        take_bit;

  // shifting only inside a selected frame
  assign take_bit = frame_open & sel_active;

  ////////////////////////////////////////////////////////////
  // control state

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_open <= 1'b0;
      sel_ok     <= 1'b0;
      bit_cnt    <= '0;
      wr_strobe  <= 1'b0;
      tx_sh      <= 8'hff;
    end
    else
    begin
      wr_strobe <= 1'b0;

      if (frame_start)
      begin
        frame_open <= 1'b1;
        sel_ok     <= sel_active;
        bit_cnt    <= '0;
        tx_sh      <= IDENT_BYTE;
      end
      else if (frame_end)
      begin
        frame_open <= 1'b0;
        // full frame and never deselected
        wr_strobe  <= (bit_cnt == CNT_FULL) & sel_ok & sel_active;
        // back to idle high
        tx_sh      <= 8'hff;
      end
      else if (frame_open)
      begin
        // dropping special_n mid-frame spoils the write
        if (!sel_active)
          sel_ok <= 1'b0;

        if (take_bit && sclk_rise && bit_cnt != CNT_SAT)
          bit_cnt <= bit_cnt + 5'd1;

        // next bit out on falling sclk
        if (take_bit && sclk_fall)
        begin
          if (bit_cnt == CNT_LOAD)
            tx_sh <= {4'h0, rd_data};
          else
            tx_sh <= {tx_sh[6:0], 1'b1};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload

  always_ff @(posedge clk)
  begin
    if (take_bit && sclk_rise)
    begin
      shift_in <= {shift_in[14:0], mosi_s};
      // eighth bit completes the address
      if (bit_cnt == CNT_ADDR)
        rd_addr <= {shift_in[6:0], mosi_s};
    end
  end

  // high byte address, low byte clear/set nibbles
  assign wr_addr = shift_in[15:8];
  assign wr_val  = shift_in[7:0];

  assign dout = tx_sh[7];

endmodule

`default_nettype wire

// ==== ctl_register_file.sv ====
// eight 4-bit control registers with set/clear/toggle writes
// soft reset by address, combinational read port
`timescale 1ns/100ps
`default_nettype none

module ctl_register_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_strobe,
  input  logic [7:0]            wr_addr,
  input  logic [7:0]            wr_val,
  input  logic [7:0]            rd_addr,
  output smu_ctl_pkg::ctl_nib_t rd_data,
  output smu_ctl_pkg::ctl_nib_t mux_sel,
  output smu_ctl_pkg::ctl_nib_t led,
  output smu_ctl_pkg::ctl_nib_t dac,
  output smu_ctl_pkg::ctl_nib_t rails,
  output smu_ctl_pkg::ctl_nib_t rails_oe,
  output smu_ctl_pkg::ctl_nib_t dac_ref_mux,
  output smu_ctl_pkg::ctl_nib_t adc,
  output smu_ctl_pkg::ctl_nib_t clamp1
);

  import smu_ctl_pkg::*;

  ctl_nib_t regs [NUM_CTL];

  logic     wr_hit;
  ctl_idx_t wr_idx;
  logic     rd_hit;
  ctl_idx_t rd_idx;

  ////////////////////////////////////////////////////////////
  // helpers

  // address to array slot, hit low for anything not kept
  function automatic logic decode(input logic [7:0] addr, output ctl_idx_t idx);
    logic hit;
    hit = 1'b1;
    idx = IDX_LED;
    case (addr)
      ADDR_LED:         idx = IDX_LED;
      ADDR_MUX:         idx = IDX_MUX;
      ADDR_DAC:         idx = IDX_DAC;
      ADDR_RAILS:       idx = IDX_RAILS;
      ADDR_DAC_REF_MUX: idx = IDX_DAC_REF_MUX;
      ADDR_ADC:         idx = IDX_ADC;
      ADDR_CLAMP1:      idx = IDX_CLAMP1;
      ADDR_RAILS_OE:    idx = IDX_RAILS_OE;
      default:          hit = 1'b0;
    endcase
    return hit;
  endfunction

  // set in val[3:0], clear in val[7:4]
  // overlapping bits toggle, otherwise set then clear
  function automatic ctl_nib_t update(input ctl_nib_t old, input logic [7:0] val);
    ctl_nib_t set_b;
    ctl_nib_t clr_b;
    ctl_nib_t both;
    set_b = val[3:0];
    clr_b = val[7:4];
    both  = set_b & clr_b;
    if (|both)
      return old ^ both;
    return (old | set_b) & ~clr_b;
  endfunction

  always_comb
  begin
    wr_hit = decode(wr_addr, wr_idx);
    rd_hit = decode(rd_addr, rd_idx);
  end

  ////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_CTL; i++)
        regs[i] <= CTL_DEFAULTS[4*i +: 4];
    end
    else if (wr_strobe)
    begin
      if (wr_addr == ADDR_SOFT_RST)
      begin
        for (int i = 0; i < NUM_CTL; i++)
          regs[i] <= CTL_DEFAULTS[4*i +: 4];
      end
      else if (wr_hit)
        regs[wr_idx] <= update(regs[wr_idx], wr_val);
    end
  end

  // soft reset address is not decoded, so it reads zero
  assign rd_data = rd_hit ? regs[rd_idx] : '0;

  // board outputs
  assign led         = regs[IDX_LED];
  assign mux_sel     = regs[IDX_MUX];
  assign dac         = regs[IDX_DAC];
  assign rails       = regs[IDX_RAILS];
  assign dac_ref_mux = regs[IDX_DAC_REF_MUX];
  assign adc         = regs[IDX_ADC];
  assign clamp1      = regs[IDX_CLAMP1];
  assign rails_oe    = regs[IDX_RAILS_OE];

endmodule

`default_nettype wire

// ==== spi_peripheral_route.sv ====
// chip-select fan-out to the downstream peripherals
// miso select between local readback and peripherals
`timescale 1ns/100ps
`default_nettype none

module spi_peripheral_route (
  input  logic                  cs_n,
  input  logic                  special_n,
  input  logic                  dout,
  input  smu_ctl_pkg::ctl_nib_t mux_sel,
  input  logic [3:0]            miso_vec,
  output logic [3:0]            cs_vec,
  output logic                  miso
);

  import smu_ctl_pkg::*;

  logic periph_sel;

  // special_n low addresses the register bank, never a peripheral
  assign periph_sel = special_n & ~cs_n;

  always_comb
  begin
    // active low selects, one per mux bit
    for (int i = 0; i < NUM_PERIPH; i++)
      cs_vec[i] = ~(periph_sel & mux_sel[i]);
  end

  // local readback, or wired-or of the selected peripherals
  // unselected peripherals are masked off
  assign miso = special_n ? |(miso_vec & mux_sel) : dout;

endmodule

`default_nettype wire

// ==== smu_ctl_top.sv ====
// board-control top level
// pin sync, frame shifter, register file, peripheral routing
`timescale 1ns/100ps
`default_nettype none

module smu_ctl_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  special_n,
  input  logic                  mosi,
  input  logic [3:0]            miso_vec,
  output logic                  miso,
  output logic [3:0]            cs_vec,
  output smu_ctl_pkg::ctl_nib_t led,
  output smu_ctl_pkg::ctl_nib_t mux_sel,
  output smu_ctl_pkg::ctl_nib_t dac,
  output smu_ctl_pkg::ctl_nib_t rails,
  output smu_ctl_pkg::ctl_nib_t rails_oe,
  output smu_ctl_pkg::ctl_nib_t dac_ref_mux,
  output smu_ctl_pkg::ctl_nib_t adc,
  output smu_ctl_pkg::ctl_nib_t clamp1
);

  import smu_ctl_pkg::*;

  // sync to shifter
  logic sclk_rise;
  logic sclk_fall;
  logic frame_start;
  logic frame_end;
  logic sel_active;
  logic mosi_s;

  // shifter to register file
  logic       wr_strobe;
  logic [7:0] wr_addr;
  logic [7:0] wr_val;
  logic [7:0] rd_addr;
  ctl_nib_t   rd_data;

  // local readback bit
  logic dout;

  ////////////////////////////////////////////////////////////
  // spi slave path

  spi_input_sync spi_input_sync_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sel_active  (sel_active),
    .mosi_s      (mosi_s)
  );

  spi_frame_shifter spi_frame_shifter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sel_active  (sel_active),
    .mosi_s      (mosi_s),
    .rd_data     (rd_data),
    .wr_strobe   (wr_strobe),
    .wr_addr     (wr_addr),
    .wr_val      (wr_val),
    .rd_addr     (rd_addr),
    .dout        (dout)
  );

  ctl_register_file ctl_register_file_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_strobe   (wr_strobe),
    .wr_addr     (wr_addr),
    .wr_val      (wr_val),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .mux_sel     (mux_sel),
    .led         (led),
    .dac         (dac),
    .rails       (rails),
    .rails_oe    (rails_oe),
    .dac_ref_mux (dac_ref_mux),
    .adc         (adc),
    .clamp1      (clamp1)
  );

  ////////////////////////////////////////////////////////////
  // peripheral routing, straight from the pins

  spi_peripheral_route spi_peripheral_route_inst (
    .cs_n      (cs_n),
    .special_n (special_n),
    .dout      (dout),
    .mux_sel   (mux_sel),
    .miso_vec  (miso_vec),
    .cs_vec    (cs_vec),
    .miso      (miso)
  );

endmodule

`default_nettype wire

// ==== smu_ctl_sva.sv ====
// concurrent checks bound to the board-control top level
// peripheral selects and miso source
`timescale 1ns/100ps
`default_nettype none

module smu_ctl_sva (
  input logic       clk,
  input logic       rst_n,
  input logic       cs_n,
  input logic       special_n,
  input logic       dout,
  input logic       miso,
  input logic [3:0] cs_vec
);

  // register bank addressed, no peripheral may see a select
  a_cs_idle_local: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> (cs_vec == 4'hf))
    else $error("cs_vec active while special_n is low");

  // no frame open, every select stays high
  a_cs_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> (cs_vec == 4'hf))
    else $error("cs_vec active while cs_n is high");

  // local readback drives miso
  a_miso_local: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> (miso == dout))
    else $error("miso differs from dout while special_n is low");

endmodule

bind smu_ctl_top smu_ctl_sva smu_ctl_sva_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .cs_n      (cs_n),
  .special_n (special_n),
  .dout      (dout),
  .miso      (miso),
  .cs_vec    (cs_vec)
);

`default_nettype wire

// ==== tb_smu_ctl.sv ====
// testbench for the board-control top level
// spi frame driver, reference register model, output checker, timeout
`timescale 1ns/100ps
`default_nettype none

module tb_smu_ctl;

  import smu_ctl_pkg::*;

  localparam int SCLK_HALF  = 8;
  localparam int MAX_CYCLES = 80000;
  localparam int NUM_RAND   = 150;
  localparam int NUM_ROUTE  = 16;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       sclk;
  logic       cs_n;
  logic       special_n;
  logic       mosi;
  logic [3:0] miso_vec;
  logic       miso;
  logic [3:0] cs_vec;
  logic [3:0] led, mux_sel, dac, rails, rails_oe, dac_ref_mux, adc, clamp1;

  // outputs in slot order, and the expected copy
  logic [3:0]  dut_regs [NUM_CTL];
  logic [3:0]  model [NUM_CTL];
  logic [31:0] rng_state;
  int          cycles = 0;
  int          checks_req = 0;
  int          checks_done = 0;

  smu_ctl_top smu_ctl_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .miso_vec    (miso_vec),
    .miso        (miso),
    .cs_vec      (cs_vec),
    .led         (led),
    .mux_sel     (mux_sel),
    .dac         (dac),
    .rails       (rails),
    .rails_oe    (rails_oe),
    .dac_ref_mux (dac_ref_mux),
    .adc         (adc),
    .clamp1      (clamp1)
  );

  assign dut_regs[0] = led;
  assign dut_regs[1] = mux_sel;
  assign dut_regs[2] = dac;
  assign dut_regs[3] = rails;
  assign dut_regs[4] = dac_ref_mux;
  assign dut_regs[5] = adc;
  assign dut_regs[6] = clamp1;
  assign dut_regs[7] = rails_oe;

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model

  // next value after a set/clear byte
  function automatic logic [3:0] ref_next(input logic [3:0] old, input logic [7:0] wr_byte);
    logic [3:0] set_n;
    logic [3:0] clr_n;
    logic [3:0] nxt;
    set_n = wr_byte[3:0];
    clr_n = wr_byte[7:4];
    nxt   = old;
    for (int b = 0; b < 4; b++)
    begin
      // any overlap means toggle mode for the whole write
      if ((set_n & clr_n) != 4'h0)
        nxt[b] = (set_n[b] && clr_n[b]) ? ~old[b] : old[b];
      else if (clr_n[b])
        nxt[b] = 1'b0;
      else if (set_n[b])
        nxt[b] = 1'b1;
    end
    return nxt;
  endfunction

  // power-up value per slot
  function automatic logic [3:0] ref_default(input int slot);
    case (slot)
      4, 6:    return 4'hf;
      7:       return 4'h1;
      default: return 4'h0;
    endcase
  endfunction

  // high when any peripheral line with its select bit set is high
  function automatic logic selected_or(input logic [3:0] sel, input logic [3:0] lines);
    logic any;
    any = 1'b0;
    for (int b = 0; b < 4; b++)
      if (sel[b] && lines[b])
        any = 1'b1;
    return any;
  endfunction

  function automatic logic [7:0] addr_of(input int slot);
    case (slot)
      0:       return ADDR_LED;
      1:       return ADDR_MUX;
      2:       return ADDR_DAC;
      3:       return ADDR_RAILS;
      4:       return ADDR_DAC_REF_MUX;
      5:       return ADDR_ADC;
      6:       return ADDR_CLAMP1;
      default: return ADDR_RAILS_OE;
    endcase
  endfunction

  function automatic string name_of(input int slot);
    case (slot)
      0:       return "led";
      1:       return "mux_sel";
      2:       return "dac";
      3:       return "rails";
      4:       return "dac_ref_mux";
      5:       return "adc";
      6:       return "clamp1";
      default: return "rails_oe";
    endcase
  endfunction

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  ////////////////////////////////////////////////////////////
  // checking

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // register outputs checked against the model once per request
  always @(posedge clk)
  begin
    if (checks_done != checks_req)
    begin
      for (int i = 0; i < NUM_CTL; i++)
        compare(name_of(i), {28'h0, dut_regs[i]}, {28'h0, model[i]});
      checks_done <= checks_req;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d clock cycles, the test did not finish", cycles);
      $display("Regression failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  task automatic request_check();
    checks_req = checks_req + 1;
    @(negedge clk);
  endtask

  // msb first with miso sampled just before each rising sclk
  task automatic send_frame(input logic [31:0] bits, input int nbits, output logic [15:0] rx);
    rx   = '0;
    cs_n = 1'b0;
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = bits[i];
      repeat (SCLK_HALF) @(negedge clk);
      rx   = {rx[14:0], miso};
      sclk = 1'b1;
      repeat (SCLK_HALF) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (SCLK_HALF) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    // register update lands within this wait
    repeat (SCLK_HALF) @(negedge clk);
  endtask

  // write plus readback of the pre-write value
  task automatic write_reg(input int slot, input logic [7:0] val);
    logic [15:0] rx;
    logic [3:0]  pre;
    pre = model[slot];
    send_frame({16'h0, addr_of(slot), val}, 16, rx);
    compare("miso", {16'h0, rx}, {16'h0, IDENT_BYTE, 4'h0, pre});
    model[slot] = ref_next(pre, val);
    request_check();
  endtask

  initial
  begin : stimulus
    logic [31:0] r;
    logic [15:0] rx;
    rng_state = 32'h39b9_f22e;
    rst_n     = 1'b0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    special_n = 1'b0;
    mosi      = 1'b0;
    miso_vec  = 4'h0;
    for (int i = 0; i < NUM_CTL; i++)
      model[i] = ref_default(i);
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    request_check();

    // random set, clear and toggle writes
    for (int n = 0; n < NUM_RAND; n++)
    begin
      r = next_rand();
      write_reg(int'(r[2:0]), r[15:8]);
    end

    // soft reset reads back zero, then all defaults
    // low nibble zero so the short frame below lines up on the dac address
    r = next_rand();
    send_frame({16'h0, ADDR_SOFT_RST, r[7:4], 4'h0}, 16, rx);
    compare("miso", {16'h0, rx}, {16'h0, IDENT_BYTE, 8'h00});
    for (int i = 0; i < NUM_CTL; i++)
      model[i] = ref_default(i);
    request_check();

    // short, long and deselected frames are dropped
    send_frame({20'h0, ADDR_DAC[3:0], 8'hff}, 12, rx);
    request_check();
    send_frame({15'h0, 1'b1, ADDR_LED, 8'hff}, 17, rx);
    request_check();
    special_n = 1'b1;
    repeat (4) @(negedge clk);
    send_frame({16'h0, ADDR_CLAMP1, 8'hff}, 16, rx);
    special_n = 1'b0;
    repeat (4) @(negedge clk);
    request_check();

    // peripheral routing
    for (int n = 0; n < NUM_ROUTE; n++)
    begin
      r = next_rand();
      // set the new mask, clear the rest
      write_reg(1, {~r[3:0], r[3:0]});
      special_n = 1'b1;
      @(negedge clk);
      compare("cs_vec", {28'h0, cs_vec}, 32'hf);
      cs_n = 1'b0;
      for (int k = 0; k < 4; k++)
      begin
        r        = next_rand();
        miso_vec = r[3:0];
        @(negedge clk);
        compare("cs_vec", {28'h0, cs_vec}, {28'h0, ~model[1]});
        compare("miso", {31'h0, miso}, {31'h0, selected_or(model[1], miso_vec)});
      end
      cs_n = 1'b1;
      @(negedge clk);
      compare("cs_vec", {28'h0, cs_vec}, 32'hf);
      special_n = 1'b0;
      miso_vec  = 4'h0;
      repeat (4) @(negedge clk);
    end
    request_check();

    if (checks_done != checks_req)
    begin
      $display("Output checks were still pending when the stimulus ended");
      $display("Regression failed");
      $fatal(1);
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
smu_ctl_pkg.sv
spi_input_sync.sv
spi_frame_shifter.sv
ctl_register_file.sv
spi_peripheral_route.sv
smu_ctl_top.sv
smu_ctl_sva.sv
tb_smu_ctl.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat verilog.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_smu_ctl: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_smu_ctl -f verilog.f

run: obj_dir/Vtb_smu_ctl
	@out="$$(./obj_dir/Vtb_smu_ctl)"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
